/* include/fetch_macros.svh */
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// isa and reset constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define ISA_WIDTH   32               // data and address width.
`define RESET_PC    32'h8000_0000    // first fetch address.
`define TRAP_VECTOR 32'h8000_0100    // mtvec after reset.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define MEM_LATENCY 2                // wait cycles of one read.

`endif

/* rtl/isa_pkg.sv */
`default_nettype none

`include "fetch_macros.svh"

package isa_pkg;

    typedef logic [`ISA_WIDTH-1:0] word_t;    // instruction or operand.
    typedef logic [`ISA_WIDTH-1:0] addr_t;    // pc values and targets.
    typedef logic [4:0]            reg_idx_t;
    typedef logic [6:0]            opcode_t;
    typedef logic [2:0]            funct3_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control-flow opcodes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam opcode_t OP_JAL    = 7'b110_1111;
    localparam opcode_t OP_JALR   = 7'b110_0111;
    localparam opcode_t OP_BRANCH = 7'b110_0011;
    localparam opcode_t OP_SYSTEM = 7'b111_0011;

    // branch funct3 values
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    localparam word_t ECALL_WORD = 32'h0000_0073;    // only full system words decoded.
    localparam word_t MRET_WORD  = 32'h3020_0073;

endpackage

`default_nettype wire

/* rtl/ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fetch sequencer states
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [1:0] {
        S_IDLE,     // held in reset.
        S_FETCH,    // read strobe issued.
        S_WAIT,     // memory latency.
        S_EXEC      // pc update and retire.
    } seq_state_t;

    // next-pc sources
    typedef enum logic [2:0] {
        SEL_SNPC,      // pc + 4.
        SEL_PC_IMM,    // jal target.
        SEL_ALU,       // jalr target with bit 0 cleared.
        SEL_BRANCH,    // pc_imm or snpc by condition.
        SEL_MTVEC,     // ecall.
        SEL_MEPC       // mret.
    } dnpc_sel_t;

endpackage

`default_nettype wire

/* rtl/fetch_unit.sv */
`default_nettype none

`include "fetch_macros.svh"

module fetch_unit (
    input  wire                      clk,
    input  wire                      reset,

    input  wire isa_pkg::addr_t      pc_imm,
    input  wire isa_pkg::word_t      alu_result,
    input  wire isa_pkg::addr_t      mtvec,
    input  wire isa_pkg::addr_t      mepc,
    input  wire ctrl_pkg::dnpc_sel_t dnpc_sel,
    input  wire                      pc_en,

    input  wire isa_pkg::word_t      mem_rdata,
    output isa_pkg::addr_t           pc,
    output isa_pkg::addr_t           snpc,
    output isa_pkg::word_t           inst,
    output isa_pkg::addr_t           mem_addr
);

    import isa_pkg::*;
    import ctrl_pkg::*;

    addr_t dnpc;

    assign snpc = pc + addr_t'(4);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // next pc select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (dnpc_sel)
            SEL_SNPC:   dnpc = snpc;
            SEL_PC_IMM: dnpc = pc_imm;
            SEL_ALU:    dnpc = alu_result & ~addr_t'(1);    // jalr drops bit 0.
            SEL_BRANCH: dnpc = alu_result[0] ? pc_imm : snpc;
            SEL_MTVEC:  dnpc = mtvec;
            SEL_MEPC:   dnpc = mepc;
            default:    dnpc = snpc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else if (pc_en) begin
            pc <= dnpc;    // loaded at the end of exec.
        end
    end

    assign mem_addr = pc;
    assign inst     = mem_rdata;    // held stable by memory until next read.

endmodule

`default_nettype wire

/* rtl/branch_decoder.sv */
`default_nettype none

module branch_decoder (
    input  wire isa_pkg::word_t  inst,
    input  wire isa_pkg::addr_t  pc,
    input  wire isa_pkg::word_t  rs1_data,
    input  wire isa_pkg::word_t  rs2_data,

    output ctrl_pkg::dnpc_sel_t  dnpc_sel,
    output isa_pkg::addr_t       pc_imm,
    output isa_pkg::word_t       alu_result,
    output logic                 is_ecall,
    output logic                 is_mret
);

    import isa_pkg::*;
    import ctrl_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    word_t   imm_i;
    word_t   imm_b;
    word_t   imm_j;
    logic    rs_eq;
    logic    rs_lt;
    logic    rs_ltu;
    logic    br_take;
    logic    br_valid;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // immediates
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign imm_i = {{21{inst[31]}}, inst[30:20]};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    assign pc_imm = pc + ((opcode == OP_JAL) ? imm_j : imm_b);

    // branch compare
    assign rs_eq  = rs1_data == rs2_data;
    assign rs_lt  = $signed(rs1_data) < $signed(rs2_data);
    assign rs_ltu = rs1_data < rs2_data;

    always_comb begin
        br_valid = 1'b1;
        case (funct3)
            F3_BEQ:  br_take = rs_eq;
            F3_BNE:  br_take = !rs_eq;
            F3_BLT:  br_take = rs_lt;
            F3_BGE:  br_take = !rs_lt;
            F3_BLTU: br_take = rs_ltu;
            F3_BGEU: br_take = !rs_ltu;
            default: begin
                br_take  = 1'b0;
                br_valid = 1'b0;    // 010 and 011 are not branches.
            end
        endcase
    end

    assign is_ecall = inst == ECALL_WORD;
    assign is_mret  = inst == MRET_WORD;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // select key
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        dnpc_sel   = SEL_SNPC;
        alu_result = '0;
        case (opcode)
            OP_JAL: dnpc_sel = SEL_PC_IMM;
            OP_JALR: begin
                dnpc_sel   = SEL_ALU;
                alu_result = rs1_data + imm_i;
            end
            OP_BRANCH: begin
                if (br_valid) begin
                    dnpc_sel   = SEL_BRANCH;
                    alu_result = word_t'(br_take);    // condition in bit 0.
                end
            end
            OP_SYSTEM: begin
                if (is_ecall) begin
                    dnpc_sel = SEL_MTVEC;
                end else if (is_mret) begin
                    dnpc_sel = SEL_MEPC;
                end
            end
            default: dnpc_sel = SEL_SNPC;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/trap_csr.sv */
`default_nettype none

`include "fetch_macros.svh"

module trap_csr (
    input  wire                 clk,
    input  wire                 reset,

    input  wire isa_pkg::addr_t pc,
    input  wire                 pc_en,
    input  wire                 is_ecall,

    output isa_pkg::addr_t      mtvec,
    output isa_pkg::addr_t      mepc
);

    import isa_pkg::*;

    logic take_trap;

    assign take_trap = pc_en && is_ecall;    // ecall at retire.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // trap registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            mtvec <= `TRAP_VECTOR;    // fixed trap vector.
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mepc <= addr_t'(0);
        end else if (take_trap) begin
            mepc <= pc;    // address of the ecall itself.
        end
    end

endmodule

`default_nettype wire

/* rtl/mem_wait_timer.sv */
`default_nettype none

`include "fetch_macros.svh"

module mem_wait_timer (
    input  wire  clk,
    input  wire  reset,

    input  wire  timer_start,
    output logic mem_done
);

    localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

    logic [CNT_W-1:0] count;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // latency counter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (timer_start) begin
            count <= CNT_W'(`MEM_LATENCY);
        end else if (count != '0) begin
            count <= count - 1'b1;    // stops at zero.
        end
    end

    // last wait cycle.
    assign mem_done = count == CNT_W'(1);

endmodule

`default_nettype wire

/* rtl/fetch_sequencer.sv */
`default_nettype none

module fetch_sequencer (
    input  wire                  clk,
    input  wire                  reset,

    input  wire                  mem_done,
    output logic                 mem_r_en,
    output logic                 timer_start,
    output logic                 pc_en,
    output logic                 retire,
    output ctrl_pkg::seq_state_t state
);

    import ctrl_pkg::*;

    seq_state_t state_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // next state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        state_next = state;
        case (state)
            S_IDLE:  state_next = S_FETCH;
            S_FETCH: state_next = S_WAIT;
            S_WAIT: begin
                if (mem_done) begin
                    state_next = S_EXEC;    // read data now valid.
                end
            end
            S_EXEC:  state_next = S_FETCH;
            default: state_next = S_IDLE;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // strobes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign mem_r_en    = state == S_FETCH;
    assign timer_start = state == S_FETCH;
    assign pc_en       = state == S_EXEC;
    assign retire      = state == S_EXEC;    // one per instruction.

endmodule

`default_nettype wire

/* rtl/fetch_core.sv */
`default_nettype none

module fetch_core (
    input  wire                 clk,
    input  wire                 reset,

    input  wire isa_pkg::word_t rs1_data,
    input  wire isa_pkg::word_t rs2_data,

    input  wire isa_pkg::word_t mem_rdata,
    output isa_pkg::addr_t      mem_addr,
    output logic                mem_r_en,

    output isa_pkg::addr_t      pc,
    output isa_pkg::word_t      inst,
    output logic                retire
);

    import isa_pkg::*;
    import ctrl_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // internal nets
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    addr_t      pc_imm;
    word_t      alu_result;
    addr_t      mtvec;
    addr_t      mepc;
    dnpc_sel_t  dnpc_sel;
    logic       is_ecall;
    logic       pc_en;
    logic       timer_start;
    logic       mem_done;

    fetch_unit fetch_unit_i (
        .clk       (clk),
        .reset     (reset),
        .pc_imm    (pc_imm),
        .alu_result(alu_result),
        .mtvec     (mtvec),
        .mepc      (mepc),
        .dnpc_sel  (dnpc_sel),
        .pc_en     (pc_en),
        .mem_rdata (mem_rdata),
        .pc        (pc),
        .snpc      (),
        .inst      (inst),
        .mem_addr  (mem_addr)
    );

    branch_decoder branch_decoder_i (
        .inst      (inst),
        .pc        (pc),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .dnpc_sel  (dnpc_sel),
        .pc_imm    (pc_imm),
        .alu_result(alu_result),
        .is_ecall  (is_ecall),
        .is_mret   ()
    );

    trap_csr trap_csr_i (
        .clk     (clk),
        .reset   (reset),
        .pc      (pc),
        .pc_en   (pc_en),
        .is_ecall(is_ecall),
        .mtvec   (mtvec),
        .mepc    (mepc)
    );

    mem_wait_timer mem_wait_timer_i (
        .clk        (clk),
        .reset      (reset),
        .timer_start(timer_start),
        .mem_done   (mem_done)
    );

    fetch_sequencer fetch_sequencer_i (
        .clk        (clk),
        .reset      (reset),
        .mem_done   (mem_done),
        .mem_r_en   (mem_r_en),
        .timer_start(timer_start),
        .pc_en      (pc_en),
        .retire     (retire),
        .state      ()
    );

endmodule

`default_nettype wire

/* sim/fetch_core_assertions.sv */
`default_nettype none

`include "fetch_macros.svh"

module fetch_core_assertions (
    input wire clk,
    input wire reset,
    input wire mem_r_en,
    input wire timer_start,
    input wire pc_en,
    input wire retire,
    input wire mem_done
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sequencer strobes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_read_vs_update: assert property (@(posedge clk) disable iff (reset)
        !(mem_r_en && pc_en))
        else $error("mem_r_en and pc_en high in the same cycle");

    a_retire_with_update: assert property (@(posedge clk) disable iff (reset)
        retire == pc_en)
        else $error("retire differs from pc_en");

    // memory wait timer in both directions.
    a_done_after_start: assert property (@(posedge clk) disable iff (reset)
        timer_start |-> ##(`MEM_LATENCY) mem_done)
        else $error("mem_done missing after timer_start");

    a_done_has_start: assert property (@(posedge clk) disable iff (reset)
        mem_done |-> $past(timer_start, `MEM_LATENCY))
        else $error("mem_done without timer_start at the right distance");

endmodule

bind fetch_sequencer fetch_core_assertions assertions_i (
    .clk        (clk),
    .reset      (reset),
    .mem_r_en   (mem_r_en),
    .timer_start(timer_start),
    .pc_en      (pc_en),
    .retire     (retire),
    .mem_done   (mem_done)
);

`default_nettype wire

/* sim/fetch_core_tb.sv */
`default_nettype none

`include "fetch_macros.svh"

module fetch_core_tb;

    import isa_pkg::*;

    localparam int NUM_INST   = 400;
    localparam int PERIOD     = 100;
    localparam int RETIRE_GAP = `MEM_LATENCY + 2;

    logic  clk;
    logic  reset;
    word_t rs1_data;
    word_t rs2_data;
    word_t mem_rdata;
    addr_t mem_addr;
    logic  mem_r_en;
    addr_t pc;
    word_t inst;
    logic  retire;

    word_t mem_model [addr_t];    // filled on first read.
    addr_t model_pc;
    addr_t model_mepc;
    addr_t read_addr;
    logic  read_pending;
    logic  ops_pending;
    int    errors;
    int    retired;
    int    cycle;
    int    last_retire;

    fetch_core dut_i (
        .clk      (clk),
        .reset    (reset),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .mem_rdata(mem_rdata),
        .mem_addr (mem_addr),
        .mem_r_en (mem_r_en),
        .pc       (pc),
        .inst     (inst),
        .retire   (retire)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_addr(input string what, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_level(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_cycles(input string what, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("ERROR at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // random program and operands
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic word_t random_inst();
        word_t       w;
        int unsigned kind;
        w    = $urandom;
        kind = $urandom_range(0, 9);
        if (kind <= 3) begin
            w[6:0] = kind[0] ? 7'b001_0011 : 7'b011_0011;    // alu ops that fall through.
        end else if (kind == 4) begin
            w[6:0] = OP_JAL;
        end else if (kind == 5) begin
            w[6:0] = OP_JALR;
        end else if (kind <= 8) begin
            w[6:0] = OP_BRANCH;
            case ($urandom_range(0, 5))
                0:       w[14:12] = F3_BEQ;
                1:       w[14:12] = F3_BNE;
                2:       w[14:12] = F3_BLT;
                3:       w[14:12] = F3_BGE;
                4:       w[14:12] = F3_BLTU;
                default: w[14:12] = F3_BGEU;
            endcase
        end else begin
            w = ECALL_WORD;
        end
        return w;
    endfunction

    function automatic word_t mem_word(addr_t a);
        if (!mem_model.exists(a)) begin
            mem_model[a] = random_inst();
        end
        return mem_model[a];
    endfunction

    function automatic word_t random_operand();
        case ($urandom_range(0, 3))
            0:       return word_t'($urandom_range(0, 3));
            1:       return 32'hffff_fffc | word_t'($urandom_range(0, 3));    // -4 to -1.
            default: return $urandom;
        endcase
    endfunction

    // next pc as the isa defines it.
    function automatic addr_t ref_next_pc(word_t w, addr_t cur, word_t a, word_t b, addr_t epc);
        int   imm_i;
        int   imm_b;
        int   imm_j;
        logic taken;
        imm_i = int'($signed(w[31:20]));
        imm_b = int'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
        imm_j = int'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
        case (w[14:12])
            F3_BEQ:  taken = a == b;
            F3_BNE:  taken = a != b;
            F3_BLT:  taken = $signed(a) < $signed(b);
            F3_BGE:  taken = $signed(a) >= $signed(b);
            F3_BLTU: taken = a < b;
            F3_BGEU: taken = a >= b;
            default: taken = 1'b0;
        endcase
        if (w == ECALL_WORD) begin
            return `TRAP_VECTOR;
        end
        if (w == MRET_WORD) begin
            return epc;
        end
        case (w[6:0])
            OP_JAL:    return cur + addr_t'(imm_j);
            OP_JALR:   return (a + addr_t'(imm_i)) & ~addr_t'(1);
            OP_BRANCH: return taken ? cur + addr_t'(imm_b) : cur + 4;
            default:   return cur + 4;
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        addr_t next_pc;
        word_t cur_inst;
        void'($urandom(74369));
        errors       = 0;
        retired      = 0;
        last_retire  = 0;
        read_pending = 1'b0;
        ops_pending  = 1'b0;
        model_pc     = `RESET_PC;
        model_mepc   = '0;
        read_addr    = '0;
        reset        = 1'b1;
        mem_rdata    = '0;
        rs1_data     = random_operand();
        rs2_data     = random_operand();
        mem_model[`TRAP_VECTOR] = MRET_WORD;

        repeat (3) @(posedge clk);
        #10;
        reset = 1'b0;
        @(negedge clk);
        cycle = 1;
        check_addr("pc after reset", pc, `RESET_PC);
        check_level("mem_r_en after reset", mem_r_en, 1'b0);
        check_level("retire after reset", retire, 1'b0);

        while (retired < NUM_INST) begin
            @(posedge clk);
            #10;
            if (read_pending) begin
                mem_rdata    = mem_word(read_addr);    // held until the next read.
                read_pending = 1'b0;
            end
            if (ops_pending) begin
                rs1_data    = random_operand();
                rs2_data    = random_operand();
                ops_pending = 1'b0;
            end
            @(negedge clk);
            cycle++;
            if (mem_r_en) begin
                check_addr("pc at read", pc, model_pc);
                check_addr("read address", mem_addr, model_pc);
                read_addr    = mem_addr;
                read_pending = 1'b1;
            end
            if (retire) begin
                cur_inst = mem_word(model_pc);
                check_word("inst at retire", inst, cur_inst);
                check_cycles("cycles to retire", cycle - last_retire,
                             (retired == 0) ? RETIRE_GAP + 1 : RETIRE_GAP);
                next_pc = ref_next_pc(cur_inst, model_pc, rs1_data, rs2_data, model_mepc);
                if (cur_inst == ECALL_WORD) begin
                    model_mepc = model_pc;
                end
                // mret returns to the ecall, which becomes a nop so the program moves on.
                if (cur_inst == MRET_WORD && mem_model.exists(model_mepc)
                        && mem_model[model_mepc] == ECALL_WORD) begin
                    mem_model[model_mepc] = 32'h0000_0013;
                end
                model_pc    = next_pc;
                last_retire = cycle;
                ops_pending = 1'b1;
                retired++;
            end
        end

        $display("%0d instructions in %0d cycles, %0d errors", retired, cycle, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #((NUM_INST + 10) * RETIRE_GAP * PERIOD);
        $display("run hung, only %0d of %0d instructions retired", retired, NUM_INST);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
rtl/isa_pkg.sv
rtl/ctrl_pkg.sv
rtl/fetch_unit.sv
rtl/branch_decoder.sv
rtl/trap_csr.sv
rtl/mem_wait_timer.sv
rtl/fetch_sequencer.sv
rtl/fetch_core.sv
sim/fetch_core_assertions.sv
sim/fetch_core_tb.sv

/* Makefile */
# Verilator build and run of the fetch core testbench

VERILATOR  ?= verilator
TOP        ?= fetch_core_tb
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_TEXT  ?= TESTS PASSED

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
